// ==== cache_checker.sv ====
// Scoreboard of the instruction cache testbench
// Mirrors valid bits, tags and key state to predict hits and misses,
// then checks every response and the memory and key handshakes

`timescale 1ns/1ps

module cache_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  cache_pkg::fetch_req_t fetch_req_i,
  input  logic                  inval_i,
  input  logic                  valid_i,
  input  cache_pkg::fetch_rsp_t rsp_i,
  input  logic                  busy_i,
  input  logic                  mem_req_i,
  input  cache_pkg::mem_req_t   mem_req_addr_i,
  input  logic                  mem_rvalid_i,
  input  logic                  key_req_i,
  input  logic                  key_valid_i,
  input  logic                  ecc_error_i,
  output int                    error_count_o,
  output int                    check_count_o
);

  logic                         line_valid [cache_pkg::NUM_LINES];
  logic [cache_pkg::TAG_W-1:0]  line_tag [cache_pkg::NUM_LINES];
  logic                         key_pending;
  logic                         open_fetch;
  logic                         expect_hit;
  logic                         mem_seen;
  logic [cache_pkg::ADDR_W-1:0] open_addr;
  int                           cycles;
  int                           errors;
  int                           checks;

  // Memory rule: inverted address rotated left by 8
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return ~{a[23:0], a[31:24]};
  endfunction

  function automatic logic is_err_addr(input logic [31:0] a);
    return a[31:28] == 4'hf;
  endfunction

  function automatic logic [cache_pkg::INDEX_W-1:0] index_of(input logic [31:0] a);
    return a[cache_pkg::INDEX_W+1:2];
  endfunction

  function automatic logic [cache_pkg::TAG_W-1:0] tag_of(input logic [31:0] a);
    return a[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W+2];
  endfunction

  task automatic note_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic note_problem(input string what);
    errors++;
    $display("Error: %s at %0t ns", what, $time);
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
        line_valid[i] = 1'b0;
        line_tag[i]   = '0;
      end
      key_pending = 1'b0;
      open_fetch  = 1'b0;
      expect_hit  = 1'b0;
      mem_seen    = 1'b0;
      open_addr   = '0;
      cycles      = 0;
    end else begin
      checks++;
      if (key_req_i !== key_pending) begin
        note_mismatch("key request", 32'(key_req_i), 32'(key_pending));
      end
      // Busy from the accepted fetch up to and including its response
      if (busy_i !== open_fetch) begin
        note_mismatch("busy", 32'(busy_i), 32'(open_fetch));
      end
      if (ecc_error_i !== 1'b0) begin
        note_problem("tag parity error reported");
      end
      if (open_fetch) begin
        cycles++;
      end
      if (mem_req_i) begin
        mem_seen = 1'b1;
        if (!open_fetch) begin
          note_problem("memory request with no fetch open");
        end else if (expect_hit) begin
          note_problem("memory request for a fetch that should hit");
        end else if (mem_req_addr_i.addr !== open_addr) begin
          note_mismatch("memory address", mem_req_addr_i.addr, open_addr);
        end
      end
      // A fill is kept only with a good key and a clean response
      if (mem_rvalid_i && open_fetch && !key_pending && !is_err_addr(open_addr)) begin
        line_valid[index_of(open_addr)] = 1'b1;
        line_tag[index_of(open_addr)]   = tag_of(open_addr);
      end
      if (valid_i) begin
        if (!open_fetch) begin
          note_problem("response with no fetch open");
        end else begin
          checks++;
          if (rsp_i.addr !== open_addr) begin
            note_mismatch("response address", rsp_i.addr, open_addr);
          end
          if (rsp_i.rdata !== mem_word(open_addr)) begin
            note_mismatch("response data", rsp_i.rdata, mem_word(open_addr));
          end
          if (rsp_i.err !== is_err_addr(open_addr)) begin
            note_mismatch("response err", 32'(rsp_i.err), 32'(is_err_addr(open_addr)));
          end
          if (expect_hit && cycles != 2) begin
            note_mismatch("hit latency", 32'(cycles), 32'd2);
          end
          if (!expect_hit && !mem_seen) begin
            note_problem("fetch answered without a memory request");
          end
        end
        open_fetch = 1'b0;
      end
      if (req_i) begin
        open_fetch = 1'b1;
        open_addr  = fetch_req_i.addr;
        cycles     = 0;
        mem_seen   = 1'b0;
        expect_hit = !key_pending && line_valid[index_of(open_addr)]
                     && (line_tag[index_of(open_addr)] == tag_of(open_addr));
      end
      // Invalidate wins over a key arriving in the same cycle
      if (inval_i) begin
        for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
          line_valid[i] = 1'b0;
        end
        key_pending = 1'b1;
      end else if (key_valid_i && key_pending) begin
        key_pending = 1'b0;
      end
    end
  end

  assign error_count_o = errors;
  assign check_count_o = checks;

endmodule

// ==== cache_ctrl.sv ====
// Lookup and miss handling of the direct-mapped instruction cache
// Hits answer two cycles after the request, misses one cycle after rvalid
// Tag words carry even parity; a mismatch is flagged and read as a miss

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_i,
  input  cache_pkg::fetch_req_t         fetch_req_i,
  input  logic                          inval_i,
  input  logic                          key_ok_i,
  output logic                          tag_req_o,
  output logic                          tag_write_o,
  output logic [cache_pkg::INDEX_W-1:0] tag_addr_o,
  output logic [cache_pkg::DATA_W-1:0]  tag_wdata_o,
  input  logic [cache_pkg::DATA_W-1:0]  tag_rdata_i,
  output logic                          data_req_o,
  output logic                          data_write_o,
  output logic [cache_pkg::INDEX_W-1:0] data_addr_o,
  output logic [cache_pkg::DATA_W-1:0]  data_wdata_o,
  input  logic [cache_pkg::DATA_W-1:0]  data_rdata_i,
  output logic                          mem_req_o,
  output cache_pkg::mem_req_t           mem_req_addr_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  cache_pkg::mem_rsp_t           mem_rsp_i,
  output logic                          valid_o,
  output cache_pkg::fetch_rsp_t         rsp_o,
  output logic                          busy_o,
  output logic                          ecc_error_o
);

  cache_pkg::ctrl_state_e state_q, state_d;
  cache_pkg::fetch_req_t  fetch_q;
  logic [cache_pkg::NUM_LINES-1:0] valid_q;
  logic [cache_pkg::DATA_W-1:0]    rdata_q;
  logic                            err_q;

  logic [cache_pkg::INDEX_W-1:0]    req_idx, cur_idx;
  logic [cache_pkg::TAG_W-1:0]      cur_tag;
  logic [cache_pkg::TAG_WORD_W-1:0] rd_tag_word;
  logic                             line_valid, parity_ok, hit, rd_req, fill_we;

  assign req_idx = fetch_req_i.addr[cache_pkg::INDEX_W+1:2];
  assign cur_idx = fetch_q.addr[cache_pkg::INDEX_W+1:2];
  assign cur_tag = fetch_q.addr[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W+2];

  // Lookup compare
  assign rd_tag_word = tag_rdata_i[cache_pkg::TAG_WORD_W-1:0];
  assign line_valid  = valid_q[cur_idx];
  assign parity_ok   = ~^rd_tag_word;
  assign hit = line_valid && parity_ok && (rd_tag_word[cache_pkg::TAG_W-1:0] == cur_tag);
  assign ecc_error_o = (state_q == cache_pkg::LOOKUP) && line_valid && !parity_ok;

  // Bypassed fetches skip the RAMs, fills are kept only with a good key
  assign rd_req  = (state_q == cache_pkg::IDLE) && req_i && key_ok_i;
  assign fill_we = (state_q == cache_pkg::MEM_WAIT) && mem_rvalid_i && !mem_rsp_i.err
                   && key_ok_i;

  assign tag_req_o    = rd_req || fill_we;
  assign tag_write_o  = fill_we;
  assign tag_addr_o   = (state_q == cache_pkg::IDLE) ? req_idx : cur_idx;
  assign tag_wdata_o  = {{(cache_pkg::DATA_W-cache_pkg::TAG_WORD_W){1'b0}}, ^cur_tag, cur_tag};
  assign data_req_o   = tag_req_o;
  assign data_write_o = fill_we;
  assign data_addr_o  = tag_addr_o;
  assign data_wdata_o = mem_rsp_i.rdata;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::IDLE:     if (req_i) state_d = key_ok_i ? cache_pkg::LOOKUP : cache_pkg::MEM_REQ;
      cache_pkg::LOOKUP:   state_d = hit ? cache_pkg::RESPOND : cache_pkg::MEM_REQ;
      cache_pkg::MEM_REQ:  if (mem_gnt_i) state_d = cache_pkg::MEM_WAIT;
      cache_pkg::MEM_WAIT: if (mem_rvalid_i) state_d = cache_pkg::RESPOND;
      default:             state_d = cache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= cache_pkg::IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (inval_i) begin
        valid_q <= '0;
      end else if (fill_we) begin
        valid_q[cur_idx] <= 1'b1;
      end
    end
  end

  // Request address and response payload
  always_ff @(posedge clk) begin
    if ((state_q == cache_pkg::IDLE) && req_i) begin
      fetch_q <= fetch_req_i;
    end
    if ((state_q == cache_pkg::LOOKUP) && hit) begin
      rdata_q <= data_rdata_i;
      err_q   <= 1'b0;
    end else if ((state_q == cache_pkg::MEM_WAIT) && mem_rvalid_i) begin
      rdata_q <= mem_rsp_i.rdata;
      err_q   <= mem_rsp_i.err;
    end
  end

  assign mem_req_o           = (state_q == cache_pkg::MEM_REQ);
  assign mem_req_addr_o.addr = fetch_q.addr;
  assign valid_o             = (state_q == cache_pkg::RESPOND);
  assign busy_o              = (state_q != cache_pkg::IDLE);
  assign rsp_o.rdata         = rdata_q;
  assign rsp_o.addr          = fetch_q.addr;
  assign rsp_o.err           = err_q;

  // Core fetches and invalidates only while the FSM is idle
  a_core_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (req_i || inval_i) |-> !busy_o);

  // Memory data only answers a granted request
  a_mem_order : assert property (@(posedge clk) disable iff (!rst_n)
    mem_rvalid_i |-> (state_q == cache_pkg::MEM_WAIT));

endmodule

// ==== cache_pkg.sv ====
// Geometry and core/memory types of the direct-mapped instruction cache
// Shared by the controller, the RAM banks and the top level

package cache_pkg;

  // Address and word geometry
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned INDEX_W    = 4;
  localparam int unsigned NUM_LINES  = 16;
  localparam int unsigned TAG_W      = 26;
  // Tag word is the tag with one parity bit on top
  localparam int unsigned TAG_WORD_W = TAG_W + 1;

  // Core side request and response
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [ADDR_W-1:0] addr;
    logic              err;
  } fetch_rsp_t;

  // Memory side request and response
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } mem_rsp_t;

  // Controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_REQ,
    MEM_WAIT,
    RESPOND
  } ctrl_state_e;

endpackage

// ==== icache_top.sv ====
// Top level of the scrambled direct-mapped instruction cache
// Core strobe interface, req/gnt/rvalid memory port and key provider port

`timescale 1ns/1ps

module icache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  cache_pkg::fetch_req_t fetch_req_i,
  input  logic                  inval_i,
  output logic                  valid_o,
  output cache_pkg::fetch_rsp_t rsp_o,
  output logic                  busy_o,
  output logic                  mem_req_o,
  output cache_pkg::mem_req_t   mem_req_addr_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  cache_pkg::mem_rsp_t   mem_rsp_i,
  output logic                  key_req_o,
  input  logic                  key_valid_i,
  input  scr_pkg::scr_key_t     key_i,
  output logic                  ecc_error_o
);

  scr_pkg::scr_key_t             key;
  logic                          key_ok;
  logic                          tag_req, tag_write, data_req, data_write;
  logic [cache_pkg::INDEX_W-1:0] tag_addr, data_addr;
  logic [cache_pkg::DATA_W-1:0]  tag_wdata, tag_rdata, data_wdata, data_rdata;

  key_manager u_key_manager (
    .clk, .rst_n, .inval_i, .key_valid_i, .key_i, .key_req_o,
    .key_o    (key),
    .key_ok_o (key_ok)
  );

  cache_ctrl u_cache_ctrl (
    .clk, .rst_n, .req_i, .fetch_req_i, .inval_i,
    .key_ok_i     (key_ok),
    .tag_req_o    (tag_req),
    .tag_write_o  (tag_write),
    .tag_addr_o   (tag_addr),
    .tag_wdata_o  (tag_wdata),
    .tag_rdata_i  (tag_rdata),
    .data_req_o   (data_req),
    .data_write_o (data_write),
    .data_addr_o  (data_addr),
    .data_wdata_o (data_wdata),
    .data_rdata_i (data_rdata),
    .mem_req_o, .mem_req_addr_o, .mem_gnt_i, .mem_rvalid_i, .mem_rsp_i,
    .valid_o, .rsp_o, .busy_o, .ecc_error_o
  );

  scr_ram_1p u_tag_bank (
    .clk, .rst_n,
    .req_i (tag_req), .write_i (tag_write), .addr_i (tag_addr),
    .wdata_i (tag_wdata), .rdata_o (tag_rdata), .key_i (key)
  );

  scr_ram_1p u_data_bank (
    .clk, .rst_n,
    .req_i (data_req), .write_i (data_write), .addr_i (data_addr),
    .wdata_i (data_wdata), .rdata_o (data_rdata), .key_i (key)
  );

endmodule

// ==== key_manager.sv ====
// Holds the scrambling key of the cache RAMs
// An invalidate retires the key and opens a request to the key provider,
// which stays open until the provider delivers fresh key material

`timescale 1ns/1ps

module key_manager (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inval_i,
  input  logic             key_valid_i,
  input  scr_pkg::scr_key_t key_i,
  output logic             key_req_o,
  output scr_pkg::scr_key_t key_o,
  output logic             key_ok_o
);

  scr_pkg::scr_key_t key_q;
  logic              key_req_q;
  logic              key_ok_q;
  logic              key_load;

  // Provider pulses only count while a request is open
  assign key_load = key_req_q && key_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q.key   <= scr_pkg::RESET_KEY;
      key_q.nonce <= scr_pkg::RESET_NONCE;
    end else if (key_load) begin
      key_q <= key_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_req_q <= 1'b0;
      key_ok_q  <= 1'b1;
    end else if (inval_i) begin
      // A new invalidate keeps the request open even if a key lands now
      key_req_q <= 1'b1;
      key_ok_q  <= 1'b0;
    end else if (key_load) begin
      key_req_q <= 1'b0;
      key_ok_q  <= 1'b1;
    end
  end

  assign key_req_o = key_req_q;
  assign key_o     = key_q;
  assign key_ok_o  = key_ok_q;

  // Key material taken from the provider must be fully known
  a_key_known : assert property (@(posedge clk) disable iff (!rst_n)
    key_valid_i && key_req_o |-> !$isunknown(key_i));

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== scr_pkg.sv ====
// Scrambling key types and the key material loaded at reset
// Used by the key manager and the scrambled RAM banks

package scr_pkg;

  localparam int unsigned KEY_W   = 64;
  localparam int unsigned NONCE_W = 32;

  typedef struct packed {
    logic [KEY_W-1:0]   key;
    logic [NONCE_W-1:0] nonce;
  } scr_key_t;

  // Key in use until the first invalidate
  localparam logic [KEY_W-1:0]   RESET_KEY   = 64'hdddd_eeee_aaaa_dddd;
  localparam logic [NONCE_W-1:0] RESET_NONCE = 32'hbbbb_eeee;

endpackage

// ==== scr_ram_1p.sv ====
// Single-port RAM bank with a key-dependent keystream on every word
// Reads are transparent while the key is constant and garbled after a change
// Tag words sit in the low bits of the bank word

`timescale 1ns/1ps

module scr_ram_1p (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_i,
  input  logic                         write_i,
  input  logic [cache_pkg::INDEX_W-1:0] addr_i,
  input  logic [cache_pkg::DATA_W-1:0]  wdata_i,
  output logic [cache_pkg::DATA_W-1:0]  rdata_o,
  input  scr_pkg::scr_key_t             key_i
);

  logic [cache_pkg::DATA_W-1:0] mem_q [cache_pkg::NUM_LINES];
  logic [cache_pkg::DATA_W-1:0] rdata_q;
  logic [cache_pkg::DATA_W-1:0] ks;

  // Fold key and nonce down to one word, then spread the index over it
  function automatic logic [cache_pkg::DATA_W-1:0] keystream(
    input scr_pkg::scr_key_t             k,
    input logic [cache_pkg::INDEX_W-1:0] a
  );
    logic [cache_pkg::DATA_W-1:0] mix;
    mix = k.key[scr_pkg::KEY_W-1:scr_pkg::KEY_W/2] ^ k.key[scr_pkg::KEY_W/2-1:0];
    mix = mix ^ k.nonce ^ {(cache_pkg::DATA_W/cache_pkg::INDEX_W){a}};
    mix = mix ^ {mix[20:0], mix[31:21]};
    mix = mix ^ {mix[6:0], mix[31:7]};
    return mix;
  endfunction

  assign ks = keystream(key_i, addr_i);

  always_ff @(posedge clk) begin
    if (req_i && write_i) begin
      mem_q[addr_i] <= wdata_i ^ ks;
    end
  end

  // Read data appears one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (req_i && !write_i) begin
      rdata_q <= mem_q[addr_i] ^ ks;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== tb.f ====
cache_pkg.sv
scr_pkg.sv
key_manager.sv
scr_ram_1p.sv
cache_ctrl.sv
icache_top.sv
cache_checker.sv
tb_top.sv

// ==== tb_top.sv ====
// Testbench of the scrambled instruction cache
// Drives random fetches and invalidates from an LFSR, models the memory
// and the key provider, and prints the verdict of the checker

`timescale 1ns/1ps

module tb_top;

  localparam int NUM_FETCHES = 400;
  localparam int MAX_DLY     = 3;
  // Idle gap, invalidate, lookup, both memory delays and the response
  localparam int WORST_FETCH     = 2 * MAX_DLY + 14;
  localparam int WATCHDOG_CYCLES = NUM_FETCHES * WORST_FETCH + 100;
  localparam logic [31:0] LFSR_SEED = 32'h0f72_db6a;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Pairs share an index; the 0xf pair answers with err
  localparam logic [31:0] ADDR_POOL [8] = '{
    32'h0000_1004, 32'h0000_2004, 32'h0000_1008, 32'h0040_1008,
    32'hf000_0010, 32'hf000_0050, 32'h1234_5678, 32'h8000_0038
  };

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  req;
  cache_pkg::fetch_req_t fetch_req;
  logic                  inval;
  logic                  valid;
  cache_pkg::fetch_rsp_t rsp;
  logic                  busy;
  logic                  mem_req;
  cache_pkg::mem_req_t   mem_req_addr;
  logic                  mem_gnt;
  logic                  mem_rvalid;
  cache_pkg::mem_rsp_t   mem_rsp;
  logic                  key_req;
  logic                  key_valid;
  scr_pkg::scr_key_t     key;
  logic                  ecc_error;
  logic [31:0]           lfsr_q = LFSR_SEED;
  int                    error_count;
  int                    check_count;

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        lsb;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (lsb ? LFSR_TAPS : 32'h0);
      bits   = {bits[30:0], lsb};
    end
    return bits;
  endfunction

  always #10 clk = ~clk;

  icache_top UUT (
    .clk, .rst_n,
    .req_i (req), .fetch_req_i (fetch_req), .inval_i (inval),
    .valid_o (valid), .rsp_o (rsp), .busy_o (busy),
    .mem_req_o (mem_req), .mem_req_addr_o (mem_req_addr), .mem_gnt_i (mem_gnt),
    .mem_rvalid_i (mem_rvalid), .mem_rsp_i (mem_rsp),
    .key_req_o (key_req), .key_valid_i (key_valid), .key_i (key),
    .ecc_error_o (ecc_error)
  );

  cache_checker u_checker (
    .clk, .rst_n,
    .req_i (req), .fetch_req_i (fetch_req), .inval_i (inval),
    .valid_i (valid), .rsp_i (rsp), .busy_i (busy), .mem_req_i (mem_req),
    .mem_req_addr_i (mem_req_addr), .mem_rvalid_i (mem_rvalid),
    .key_req_i (key_req), .key_valid_i (key_valid), .ecc_error_i (ecc_error),
    .error_count_o (error_count), .check_count_o (check_count)
  );

  // Memory with random grant and rvalid delays
  initial begin : memory_model
    logic [31:0] a;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rsp    = '0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req) begin
        repeat (rand_bits(2)) @(negedge clk);
        a       = mem_req_addr.addr;
        mem_gnt = 1'b1;
        @(negedge clk);
        mem_gnt = 1'b0;
        repeat (rand_bits(2)) @(negedge clk);
        mem_rsp.rdata = ~{a[23:0], a[31:24]};
        mem_rsp.err   = (a[31:28] == 4'hf);
        mem_rvalid    = 1'b1;
        @(negedge clk);
        mem_rvalid = 1'b0;
      end
    end
  end

  // Key provider, slow enough that fetches run in bypass meanwhile
  initial begin : key_provider
    key_valid = 1'b0;
    key       = '0;
    forever begin
      @(negedge clk);
      if (rst_n && key_req) begin
        repeat (rand_bits(6)) @(negedge clk);
        key.key   = {rand_bits(32), rand_bits(32)};
        key.nonce = rand_bits(32);
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [2:0] pick;
    int         n;
    rst_n     = 1'b0;
    req       = 1'b0;
    fetch_req = '0;
    inval     = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (n = 0; n < NUM_FETCHES; n++) begin
      repeat (rand_bits(2)) @(negedge clk);
      if (rand_bits(4) == 32'd0) begin
        inval = 1'b1;
        @(negedge clk);
        inval = 1'b0;
      end
      pick           = 3'(rand_bits(3));
      fetch_req.addr = ADDR_POOL[pick];
      req            = 1'b1;
      @(negedge clk);
      req = 1'b0;
      while (!valid) @(negedge clk);
      // busy_o drops one cycle after the response
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the cache stopped answering before all fetches were done");
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Regression failed");
    $finish;
  end

endmodule
